/* common/rv_ctrl_pkg.sv */
// RV32I control decode definitions
`default_nettype none

package rv_ctrl_pkg;

    // Fixed ISA field widths
    localparam int XLEN     = 32;                  // Instruction width
    localparam int OPCODE_W = 7;                   // inst[6:0]
    localparam int FUNCT3_W = 3;                   // inst[14:12]
    localparam int FUNCT7_W = 7;                   // inst[31:25]

    // Major opcodes handled by the decode stage
    typedef enum logic [OPCODE_W-1:0] {
        OP_REG    = 7'b0110011,                    // R-type ALU
        OP_IMM    = 7'b0010011,                    // I-type ALU
        OP_BRANCH = 7'b1100011,                    // Conditional branches
        OP_JALR   = 7'b1100111,                    // Jump and link register
        OP_SYSTEM = 7'b1110011                     // ECALL, EBREAK and CSR space
    } opcode_e;

    // ALU operation codes seen by the execute stage
    typedef enum logic [4:0] {
        ALU_ADD  = 5'd0,
        ALU_SUB  = 5'd1,
        ALU_SLT  = 5'd2,
        ALU_SLTU = 5'd3,
        ALU_XOR  = 5'd4,
        ALU_OR   = 5'd5,
        ALU_AND  = 5'd6,
        ALU_SLL  = 5'd7,
        ALU_SRL  = 5'd8,
        ALU_SRA  = 5'd9
    } alu_op_e;

    // Operand 1 source
    typedef enum logic [1:0] {
        OP1_RS1 = 2'd0                             // Only rs1 in this ISA subset
    } op1_sel_e;

    // Operand 2 source
    typedef enum logic [1:0] {
        OP2_RS2   = 2'd0,                          // Branch and EBREAK default
        OP2_IMM   = 2'd1,                          // I-type immediate
        OP2_RS2_R = 2'd3                           // Register form code
    } op2_sel_e;

    // Next PC source
    typedef enum logic [2:0] {
        PC_PLUS4  = 3'd0,
        PC_JALR   = 3'd1,
        PC_BRANCH = 3'd2
    } pc_sel_e;

    // Write-back source
    typedef enum logic [1:0] {
        WB_NONE = 2'd0,
        WB_PC4  = 2'd1,                            // Link address for JALR
        WB_ALU  = 2'd2
    } wb_sel_e;

    // Branch funct3 values
    localparam logic [FUNCT3_W-1:0] F3_BEQ  = 3'b000;
    localparam logic [FUNCT3_W-1:0] F3_BLT  = 3'b100;
    localparam logic [FUNCT3_W-1:0] F3_BLTU = 3'b110;

    // funct7 values
    localparam logic [FUNCT7_W-1:0] F7_BASE = 7'b0000000;
    localparam logic [FUNCT7_W-1:0] F7_ALT  = 7'b0100000;   // SUB, SRA, SRAI

    // imm=1, rs1=0, funct3=0, rd=0, SYSTEM
    localparam logic [XLEN-1:0] EBREAK_INST = 32'h0010_0073;

endpackage

`default_nettype wire

/* decode/alu_decoder.sv */
// Datapath control decoder
`timescale 1ns/1ps
`default_nettype none

module alu_decoder import rv_ctrl_pkg::*; (
    input  logic [XLEN-1:0] inst,                  // Raw instruction
    output alu_op_e         alu_op,                // ALU operation
    output op1_sel_e        op1_sel,               // Operand 1 source
    output op2_sel_e        op2_sel,               // Operand 2 source
    output wb_sel_e         wb_sel,                // Write-back source
    output logic            rf_we_req,             // Register write wanted
    output logic            alu_known              // Encoding recognised here
);

    opcode_e               opcode;
    logic [FUNCT3_W-1:0]   funct3;
    logic [FUNCT7_W-1:0]   funct7;

    assign opcode = opcode_e'(inst[OPCODE_W-1:0]);
    assign funct3 = inst[14:12];
    assign funct7 = inst[31:25];

    // Writing forms only, branches and EBREAK never write
    assign rf_we_req = alu_known &&
                       (opcode == OP_REG || opcode == OP_IMM || opcode == OP_JALR);

    always_comb begin
        alu_op    = ALU_ADD;                       // Safe default, no side effects
        op1_sel   = OP1_RS1;
        op2_sel   = OP2_RS2;
        wb_sel    = WB_NONE;
        alu_known = 1'b0;
        case (opcode)
            OP_REG: begin
                op2_sel   = OP2_RS2_R;
                alu_known = 1'b1;                  // Cleared on unknown funct pair
                case ({funct7, funct3})            // funct7 checked for every funct3
                    {F7_BASE, 3'b000}: alu_op = ALU_ADD;
                    {F7_ALT,  3'b000}: alu_op = ALU_SUB;
                    {F7_BASE, 3'b001}: alu_op = ALU_SLL;
                    {F7_BASE, 3'b010}: alu_op = ALU_SLT;
                    {F7_BASE, 3'b011}: alu_op = ALU_SLTU;
                    {F7_BASE, 3'b100}: alu_op = ALU_XOR;
                    {F7_BASE, 3'b101}: alu_op = ALU_SRL;
                    {F7_ALT,  3'b101}: alu_op = ALU_SRA;
                    {F7_BASE, 3'b110}: alu_op = ALU_OR;
                    {F7_BASE, 3'b111}: alu_op = ALU_AND;
                    default:           alu_known = 1'b0;
                endcase
                if (alu_known) begin
                    wb_sel    = WB_ALU;
                end
            end
            OP_IMM: begin
                op2_sel   = OP2_IMM;
                alu_known = 1'b1;
                case (funct3)                      // funct7 only matters for shifts
                    3'b000: alu_op = ALU_ADD;      // ADDI
                    3'b010: alu_op = ALU_SLT;      // SLTI
                    3'b011: alu_op = ALU_SLTU;     // SLTIU
                    3'b100: alu_op = ALU_XOR;      // XORI
                    3'b110: alu_op = ALU_OR;       // ORI
                    3'b111: alu_op = ALU_AND;      // ANDI
                    3'b001: begin                  // SLLI
                        alu_op    = ALU_SLL;
                        alu_known = (funct7 == F7_BASE);
                    end
                    default: begin                 // 3'b101, SRLI or SRAI
                        if (funct7 == F7_BASE) alu_op = ALU_SRL;
                        else if (funct7 == F7_ALT) alu_op = ALU_SRA;
                        else alu_known = 1'b0;
                    end
                endcase
                if (alu_known) begin
                    wb_sel    = WB_ALU;
                end
            end
            OP_JALR: begin
                op2_sel   = OP2_IMM;               // rs1 + imm target
                wb_sel    = WB_PC4;                // Link register gets PC+4
                alu_known = 1'b1;                  // funct3 is checked by flow_decoder
            end
            OP_BRANCH: alu_known = 1'b1;           // No write, compare done upstream
            OP_SYSTEM: alu_known = (inst == EBREAK_INST);   // Only EBREAK here
            default:   alu_known = 1'b0;
        endcase
    end

    // Sampled on each new instruction, so it checks the settled previous decode
    a_we_has_source: assert property (@(inst) rf_we_req |-> (wb_sel != WB_NONE))
        else $error("alu_decoder: register write without a write-back source");

endmodule

`default_nettype wire

/* decode/ctrl_register.sv */
// Registered control word output
`timescale 1ns/1ps
`default_nettype none

module ctrl_register import rv_ctrl_pkg::*; (
    input  logic     clk,
    input  logic     rst,                          // Sync, active high
    input  logic     inst_valid,                   // One-cycle strobe
    input  alu_op_e  dec_alu_op,                   // From alu_decoder
    input  op1_sel_e dec_op1_sel,
    input  op2_sel_e dec_op2_sel,
    input  wb_sel_e  dec_wb_sel,
    input  logic     rf_we_req,
    input  logic     alu_known,
    input  pc_sel_e  dec_pc_sel,                   // From flow_decoder
    input  logic     dec_ebreak,
    input  logic     flow_illegal,
    output alu_op_e  alu_op,
    output op1_sel_e op1_sel,
    output op2_sel_e op2_sel,
    output pc_sel_e  pc_sel,
    output wb_sel_e  wb_sel,
    output logic     rf_we,
    output logic     ebreak,
    output logic     illegal,
    output logic     ctl_valid                     // Controls valid this cycle
);

    logic is_illegal;                              // Either decoder rejected it

    assign is_illegal = flow_illegal || !alu_known;

    always_ff @(posedge clk) begin
        if (rst) begin
            ctl_valid <= 1'b0;
            alu_op    <= ALU_ADD;                  // All selects back to zero
            op1_sel   <= OP1_RS1;
            op2_sel   <= OP2_RS2;
            pc_sel    <= PC_PLUS4;
            wb_sel    <= WB_NONE;
            rf_we     <= 1'b0;
            ebreak    <= 1'b0;
            illegal   <= 1'b0;
        end else begin
            ctl_valid <= inst_valid;               // Drops one cycle after a gap
            if (inst_valid) begin                  // Hold controls between strobes
                alu_op  <= dec_alu_op;
                op1_sel <= dec_op1_sel;
                op2_sel <= dec_op2_sel;
                ebreak  <= dec_ebreak;
                illegal <= is_illegal;
                rf_we   <= rf_we_req && !is_illegal;              // No write on trap
                wb_sel  <= is_illegal ? WB_NONE : dec_wb_sel;
                pc_sel  <= is_illegal ? PC_PLUS4 : dec_pc_sel;    // Skip the bad word
            end
        end
    end

    // Fixed latency of one cycle from strobe to valid
    a_valid_latency: assert property (@(posedge clk) disable iff (rst)
        inst_valid |=> ctl_valid)
        else $error("ctrl_register: ctl_valid missing one cycle after inst_valid");

    a_illegal_no_write: assert property (@(posedge clk) disable iff (rst)
        illegal |-> !rf_we)
        else $error("ctrl_register: register write on an illegal instruction");

endmodule

`default_nettype wire

/* decode/flow_decoder.sv */
// Program flow control decoder
`timescale 1ns/1ps
`default_nettype none

module flow_decoder import rv_ctrl_pkg::*; (
    input  logic [XLEN-1:0] inst,                  // Raw instruction
    input  logic            br_eq,                 // rs1 == rs2
    input  logic            br_lt,                 // rs1 < rs2 signed
    input  logic            br_ltu,                // rs1 < rs2 unsigned
    output pc_sel_e         pc_sel,                // Next PC source
    output logic            ebreak,                // Exact EBREAK match
    output logic            flow_illegal           // Bad flow-side encoding
);

    opcode_e             opcode;
    logic [FUNCT3_W-1:0] funct3;
    logic                br_taken;                 // Resolved branch condition

    assign opcode = opcode_e'(inst[OPCODE_W-1:0]);
    assign funct3 = inst[14:12];

    // Whole word compare, any nonzero field is not EBREAK
    assign ebreak = (inst == EBREAK_INST);

    always_comb begin
        br_taken     = 1'b0;
        pc_sel       = PC_PLUS4;                   // Fall through by default
        flow_illegal = 1'b0;
        case (opcode)
            OP_BRANCH: begin
                case (funct3)                      // Flag picked by compare kind
                    F3_BEQ:  br_taken = br_eq;
                    F3_BLT:  br_taken = br_lt;
                    F3_BLTU: br_taken = br_ltu;
                    default: flow_illegal = 1'b1;  // BNE, BGE, BGEU and reserved
                endcase
                if (br_taken) begin
                    pc_sel = PC_BRANCH;
                end
            end
            OP_JALR: begin
                pc_sel       = PC_JALR;
                flow_illegal = (funct3 != 3'b000); // Only funct3 0 is defined
            end
            OP_SYSTEM: begin
                flow_illegal = (inst[31:20] != 12'h001)    // Imm must be 1
                            || (inst[19:15] != 5'd0)       // rs1, funct3 and rd all zero
                            || (funct3 != 3'b000)
                            || (inst[11:7] != 5'd0);
            end
            default: begin
                flow_illegal = 1'b0;               // Opcode checks live in alu_decoder
            end
        endcase
    end

    // A legal EBREAK cannot also be a bad system encoding
    a_ebreak_not_illegal: assert property (@(inst) !(ebreak && flow_illegal))
        else $error("flow_decoder: ebreak and flow_illegal both set");

endmodule

`default_nettype wire

/* logic/decode_stage.sv */
// RV32I registered decode stage
`timescale 1ns/1ps
`default_nettype none

module decode_stage import rv_ctrl_pkg::*; (
    input  logic            clk,
    input  logic            rst,                   // Sync, active high
    input  logic [XLEN-1:0] inst,                  // Valid with the strobe only
    input  logic            inst_valid,            // One cycle per instruction
    input  logic            br_eq,                 // Branch compare flags
    input  logic            br_lt,
    input  logic            br_ltu,
    output alu_op_e         alu_op,
    output op1_sel_e        op1_sel,
    output op2_sel_e        op2_sel,
    output pc_sel_e         pc_sel,
    output wb_sel_e         wb_sel,
    output logic            rf_we,
    output logic            ebreak,
    output logic            illegal,
    output logic            ctl_valid              // One cycle after inst_valid
);

    alu_op_e  dec_alu_op;                          // Datapath side, combinational
    op1_sel_e dec_op1_sel;
    op2_sel_e dec_op2_sel;
    wb_sel_e  dec_wb_sel;
    logic     rf_we_req;
    logic     alu_known;
    pc_sel_e  dec_pc_sel;                          // Flow side, combinational
    logic     dec_ebreak;
    logic     flow_illegal;

    alu_decoder u_alu_decoder (
        .inst      (inst),
        .alu_op    (dec_alu_op),
        .op1_sel   (dec_op1_sel),
        .op2_sel   (dec_op2_sel),
        .wb_sel    (dec_wb_sel),
        .rf_we_req (rf_we_req),
        .alu_known (alu_known)
    );

    flow_decoder u_flow_decoder (
        .inst         (inst),
        .br_eq        (br_eq),
        .br_lt        (br_lt),
        .br_ltu       (br_ltu),
        .pc_sel       (dec_pc_sel),
        .ebreak       (dec_ebreak),
        .flow_illegal (flow_illegal)
    );

    ctrl_register u_ctrl_register (
        .clk          (clk),
        .rst          (rst),
        .inst_valid   (inst_valid),
        .dec_alu_op   (dec_alu_op),
        .dec_op1_sel  (dec_op1_sel),
        .dec_op2_sel  (dec_op2_sel),
        .dec_wb_sel   (dec_wb_sel),
        .rf_we_req    (rf_we_req),
        .alu_known    (alu_known),
        .dec_pc_sel   (dec_pc_sel),
        .dec_ebreak   (dec_ebreak),
        .flow_illegal (flow_illegal),
        .alu_op       (alu_op),
        .op1_sel      (op1_sel),
        .op2_sel      (op2_sel),
        .pc_sel       (pc_sel),
        .wb_sel       (wb_sel),
        .rf_we        (rf_we),
        .ebreak       (ebreak),
        .illegal      (illegal),
        .ctl_valid    (ctl_valid)
    );

endmodule

`default_nettype wire

/* sources.f */
common/rv_ctrl_pkg.sv
decode/alu_decoder.sv
decode/flow_decoder.sv
decode/ctrl_register.sv
logic/decode_stage.sv
verification/decode_stage_tb.sv

/* verification/decode_stage_tb.sv */
// Decode stage testbench
`timescale 1ns/1ps
`default_nettype none

module decode_stage_tb import rv_ctrl_pkg::*; ();

    localparam int NUM_STROBES = 32;               // 19 ALU, 6 branch, JALR, 6 EBREAK and traps
    localparam int NUM_IDLE    = 9;                // Gaps and final drain
    localparam int MAX_CYCLES  = 3 + NUM_STROBES + NUM_IDLE + 50;

    logic            clk;
    logic            rst = 1'b1;
    logic [XLEN-1:0] inst = '0;
    logic            inst_valid = 1'b0;
    logic            br_eq = 1'b0;
    logic            br_lt = 1'b0;
    logic            br_ltu = 1'b0;
    alu_op_e         alu_op;
    op1_sel_e        op1_sel;
    op2_sel_e        op2_sel;
    pc_sel_e         pc_sel;
    wb_sel_e         wb_sel;
    logic            rf_we, ebreak, illegal, ctl_valid;

    integer   seed = 69177;
    int       errors = 0;
    int       cycle_count = 0;
    alu_op_e  pend_alu, exp_alu;                   // Model result, then held for one cycle
    op2_sel_e pend_op2, exp_op2;
    pc_sel_e  pend_pc, exp_pc;
    wb_sel_e  pend_wb, exp_wb;
    logic     pend_we, exp_we, pend_ebreak, exp_ebreak, pend_illegal, exp_illegal;
    logic     exp_valid = 1'b0;
    string    pend_name, exp_name = "reset";

    decode_stage u_dut (.*);

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // ALU code for funct3 with base funct7
    function automatic alu_op_e base_op(input logic [2:0] f3);
        case (f3)
            3'd0:    return ALU_ADD;
            3'd1:    return ALU_SLL;
            3'd2:    return ALU_SLT;
            3'd3:    return ALU_SLTU;
            3'd4:    return ALU_XOR;
            3'd5:    return ALU_SRL;
            3'd6:    return ALU_OR;
            default: return ALU_AND;
        endcase
    endfunction

    function automatic logic [6:0] rnd7();
        return 7'($random(seed));
    endfunction

    // Random rd, rs1 and rs2 or low immediate bits
    function automatic logic [31:0] encode(input logic [6:0] f7, input logic [2:0] f3,
                                           input logic [6:0] opc);
        logic [31:0] r;
        r = $random(seed);
        return {f7, r[24:15], f3, r[11:7], opc};
    endfunction

    // Reference decode from the ISA tables
    task automatic predict(input logic [31:0] w, input logic [2:0] flags);
        logic [6:0] opc;
        logic [2:0] f3;
        logic [6:0] f7;
        logic       ok;
        opc = w[6:0];
        f3 = w[14:12];
        f7 = w[31:25];
        pend_alu = ALU_ADD;
        pend_op2 = OP2_RS2;
        pend_pc = PC_PLUS4;
        pend_wb = WB_NONE;
        pend_ebreak = (w == EBREAK_INST);
        if (opc == OP_REG) begin
            pend_op2 = OP2_RS2_R;
            pend_alu = (f7 == F7_ALT) ? ((f3 == 3'd0) ? ALU_SUB : ALU_SRA) : base_op(f3);
            ok = (f7 == F7_BASE) || (f7 == F7_ALT && (f3 == 3'd0 || f3 == 3'd5));
        end else if (opc == OP_IMM) begin
            pend_op2 = OP2_IMM;
            pend_alu = (f3 == 3'd5 && f7 == F7_ALT) ? ALU_SRA : base_op(f3);
            ok = (f3 != 3'd1 && f3 != 3'd5) || f7 == F7_BASE || (f3 == 3'd5 && f7 == F7_ALT);
        end else if (opc == OP_JALR) begin
            pend_op2 = OP2_IMM;
            pend_pc = PC_JALR;
            ok = (f3 == 3'd0);
        end else if (opc == OP_BRANCH) begin
            ok = (f3 == F3_BEQ) || (f3 == F3_BLT) || (f3 == F3_BLTU);
            if ((f3 == F3_BEQ && flags[0]) || (f3 == F3_BLT && flags[1]) ||
                (f3 == F3_BLTU && flags[2]))
                pend_pc = PC_BRANCH;
        end else begin
            ok = pend_ebreak;                      // Only EBREAK outside the four groups
        end
        if (ok && (opc == OP_REG || opc == OP_IMM)) pend_wb = WB_ALU;
        if (ok && opc == OP_JALR) pend_wb = WB_PC4;
        if (!ok) pend_pc = PC_PLUS4;
        pend_we = (pend_wb != WB_NONE);
        pend_illegal = !ok;
    endtask

    // One strobe cycle, flags as {ltu, lt, eq}
    task automatic strobe(input string name, input logic [31:0] w, input logic [2:0] flags);
        @(negedge clk);
        inst = w;
        inst_valid = 1'b1;
        {br_ltu, br_lt, br_eq} = flags;
        predict(w, flags);
        pend_name = name;
    endtask

    task automatic send(input string name, input logic [31:0] w);
        strobe(name, w, 3'($random(seed)));        // Flags are noise here
    endtask

    task automatic branch_pair(input string name, input logic [2:0] f3, input int idx);
        logic [2:0] flags;
        for (int t = 1; t >= 0; t--) begin         // Taken, then not taken
            flags = 3'($random(seed));
            flags[idx] = t[0];
            strobe(name, encode(rnd7(), f3, OP_BRANCH), flags);
        end
    endtask

    task automatic idle(input int n);
        repeat (n) begin
            @(negedge clk);
            inst_valid = 1'b0;
            inst = $random(seed);                  // Must be ignored
        end
    endtask

    task automatic report_mismatch(input string field, input int expected, input int actual);
        errors++;
        $display("ERROR %s %s expected %0d actual %0d", exp_name, field, expected, actual);
    endtask

    always @(posedge clk) begin
        if (rst) begin
            exp_valid <= 1'b0;
        end else begin
            exp_valid <= inst_valid;
            if (inst_valid) begin
                exp_alu <= pend_alu;
                exp_op2 <= pend_op2;
                exp_pc <= pend_pc;
                exp_wb <= pend_wb;
                exp_we <= pend_we;
                exp_ebreak <= pend_ebreak;
                exp_illegal <= pend_illegal;
                exp_name <= pend_name;
            end
        end
    end

    // Outputs settle at the rising edge, checked at the falling edge
    a_valid: assert property (@(negedge clk) disable iff (rst) ctl_valid == exp_valid)
        else report_mismatch("ctl_valid", exp_valid, ctl_valid);
    a_alu_op: assert property (@(negedge clk) disable iff (rst)
        ctl_valid && !exp_illegal |-> alu_op == exp_alu)
        else report_mismatch("alu_op", exp_alu, alu_op);
    a_op1_sel: assert property (@(negedge clk) disable iff (rst)
        ctl_valid && !exp_illegal |-> op1_sel == OP1_RS1)
        else report_mismatch("op1_sel", OP1_RS1, op1_sel);
    a_op2_sel: assert property (@(negedge clk) disable iff (rst)
        ctl_valid && !exp_illegal |-> op2_sel == exp_op2)
        else report_mismatch("op2_sel", exp_op2, op2_sel);
    a_pc_sel: assert property (@(negedge clk) disable iff (rst) ctl_valid |-> pc_sel == exp_pc)
        else report_mismatch("pc_sel", exp_pc, pc_sel);
    a_wb_sel: assert property (@(negedge clk) disable iff (rst) ctl_valid |-> wb_sel == exp_wb)
        else report_mismatch("wb_sel", exp_wb, wb_sel);
    a_rf_we: assert property (@(negedge clk) disable iff (rst) ctl_valid |-> rf_we == exp_we)
        else report_mismatch("rf_we", exp_we, rf_we);
    a_ebreak: assert property (@(negedge clk) disable iff (rst)
        ctl_valid |-> ebreak == exp_ebreak)
        else report_mismatch("ebreak", exp_ebreak, ebreak);
    a_illegal: assert property (@(negedge clk) disable iff (rst)
        ctl_valid |-> illegal == exp_illegal)
        else report_mismatch("illegal", exp_illegal, illegal);
    a_reset_flags: assert property (@(negedge clk)
        $fell(rst) |-> {ctl_valid, rf_we, ebreak, illegal} == 4'b0)
        else report_mismatch("status bits", 0, {ctl_valid, rf_we, ebreak, illegal});
    a_reset_sels: assert property (@(negedge clk)
        $fell(rst) |-> {alu_op, op1_sel, op2_sel, pc_sel, wb_sel} == '0)
        else report_mismatch("selects", 0, {alu_op, op1_sel, op2_sel, pc_sel, wb_sel});

    initial begin
        repeat (3) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        send("add", encode(F7_BASE, 3'd0, OP_REG));      // R-type back to back
        send("sub", encode(F7_ALT, 3'd0, OP_REG));
        send("sll", encode(F7_BASE, 3'd1, OP_REG));
        send("slt", encode(F7_BASE, 3'd2, OP_REG));
        send("sltu", encode(F7_BASE, 3'd3, OP_REG));
        send("xor", encode(F7_BASE, 3'd4, OP_REG));
        send("srl", encode(F7_BASE, 3'd5, OP_REG));
        send("sra", encode(F7_ALT, 3'd5, OP_REG));
        send("or", encode(F7_BASE, 3'd6, OP_REG));
        send("and", encode(F7_BASE, 3'd7, OP_REG));
        idle(2);
        send("addi", encode(rnd7(), 3'd0, OP_IMM));
        send("slti", encode(rnd7(), 3'd2, OP_IMM));
        send("sltiu", encode(rnd7(), 3'd3, OP_IMM));
        send("xori", encode(rnd7(), 3'd4, OP_IMM));
        send("ori", encode(rnd7(), 3'd6, OP_IMM));
        send("andi", encode(rnd7(), 3'd7, OP_IMM));
        send("slli", encode(F7_BASE, 3'd1, OP_IMM));
        send("srli", encode(F7_BASE, 3'd5, OP_IMM));
        send("srai", encode(F7_ALT, 3'd5, OP_IMM));
        idle(1);
        branch_pair("beq", F3_BEQ, 0);
        branch_pair("blt", F3_BLT, 1);
        branch_pair("bltu", F3_BLTU, 2);
        send("jalr", encode(rnd7(), 3'd0, OP_JALR));
        idle(2);
        send("ebreak", EBREAK_INST);
        send("ecall", 32'h0000_0073);
        send("lui unsupported", encode(rnd7(), 3'($random(seed)), 7'b0110111));
        send("bad funct7", encode(7'b0000001, 3'd0, OP_REG));
        send("bad branch funct3", encode(rnd7(), 3'b001, OP_BRANCH));
        send("bad jalr funct3", encode(rnd7(), 3'b010, OP_JALR));
        idle(4);
        $display("errors: %0d", errors);
        if (errors == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

    initial begin
        while (cycle_count < MAX_CYCLES) begin
            @(posedge clk);
            cycle_count++;
        end
        $display("ERROR timeout, stimulus still running after %0d cycles", MAX_CYCLES);
        $display("errors: %0d", errors);
        $display("SOME TESTS FAILED");
        $finish;
    end

endmodule

`default_nettype wire
